//--- corePkg.sv
package corePkg;

    // ==============================
    // Widths and opcodes
    // ==============================
    localparam int XLEN = 32;

    localparam logic [6:0] OpReg    = 7'b0110011; // ADD SUB AND OR XOR
    localparam logic [6:0] OpImm    = 7'b0010011; // ADDI
    localparam logic [6:0] OpLui    = 7'b0110111;
    localparam logic [6:0] OpLoad   = 7'b0000011; // LW
    localparam logic [6:0] OpStore  = 7'b0100011; // SW SB
    localparam logic [6:0] OpBranch = 7'b1100011; // BEQ BNE
    localparam logic [6:0] OpJal    = 7'b1101111;
    localparam logic [6:0] OpSystem = 7'b1110011; // ECALL

    // ==============================
    // Enumerations
    // ==============================
    typedef enum logic [2:0] {
        Add,
        Sub,
        And,
        Or,
        Xor,
        PassB // Immediate straight through, for LUI
    } aluOp_t;

    typedef enum logic [2:0] {
        Idle,
        Fetch,
        Execute,
        Memory,
        Retire,
        Halted
    } ctrlState_t;

    // ==============================
    // Bundles
    // ==============================
    typedef struct packed {
        logic [XLEN-1:0] addr;  // Word aligned byte address
        logic [XLEN-1:0] instr;
    } loadReq_t;

    typedef struct packed {
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] wrData;
        logic [3:0]      byteEn;
        logic            wrEn;
        logic            rdEn;
    } memReq_t;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] instr;
        logic [4:0]      rdAddr;
        logic [XLEN-1:0] rdData;
        logic            rdWrEn;
        logic            memWrEn;
        logic [XLEN-1:0] memAddr;
        logic [XLEN-1:0] memData;
        logic [3:0]      byteEn;
    } retire_t;

endpackage

//--- instMem.sv
module instMem #(
    parameter int IMemBytes = 1024
) (
    input  logic                      Clk,
    input  corePkg::loadReq_t         loadReq,
    input  logic                      loadWrEn,
    input  logic [corePkg::XLEN-1:0]  pc,
    output logic [corePkg::XLEN-1:0]  instr
);

    localparam int AddrW = $clog2(IMemBytes);

    logic [7:0]       mem [IMemBytes];
    logic [AddrW-1:0] wrBase;
    logic [AddrW-1:0] rdBase;

    assign wrBase = loadReq.addr[AddrW-1:0];
    assign rdBase = pc[AddrW-1:0];

    always_ff @(posedge Clk) begin
        if (loadWrEn) begin
            for (int lane = 0; lane < 4; lane++) begin
                mem[wrBase + AddrW'(lane)] <= loadReq.instr[8*lane +: 8];
            end
        end
    end

    // Little-endian fetch, byte at pc is the low byte
    always_comb begin
        for (int lane = 0; lane < 4; lane++) begin
            instr[8*lane +: 8] = mem[rdBase + AddrW'(lane)];
        end
    end

    // Fetch address comes from pcCounter via the branch target path
    assert property (@(posedge Clk)
        (pc[1:0] == 2'b00) && (pc <= IMemBytes - 4));

endmodule

//--- dataMem.sv
module dataMem #(
    parameter int DMemBytes  = 1024,
    parameter int DMemOffset = 1024
) (
    input  logic                      Clk,
    input  corePkg::memReq_t          memReq,
    output logic [corePkg::XLEN-1:0]  rdData
);

    localparam int AddrW = $clog2(DMemBytes);
    localparam logic [corePkg::XLEN-1:0] Base = DMemOffset;

    logic [7:0]                mem [DMemBytes];
    logic [corePkg::XLEN-1:0]  offsetAddr;
    logic [AddrW-1:0]          base;

    assign offsetAddr = memReq.addr - Base; // Window starts at DMemOffset
    assign base       = {offsetAddr[AddrW-1:2], 2'b00}; // Lanes index the aligned word

    // ==============================
    // Byte-enabled write
    // ==============================
    always_ff @(posedge Clk) begin
        if (memReq.wrEn) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (memReq.byteEn[lane]) begin
                    mem[base + AddrW'(lane)] <= memReq.wrData[8*lane +: 8];
                end
            end
        end
    end

    // ==============================
    // Word read
    // ==============================
    always_comb begin
        for (int lane = 0; lane < 4; lane++) begin
            rdData[8*lane +: 8] = mem[base + AddrW'(lane)];
        end
    end

    // Addresses are formed by the ALU from register and immediate
    assert property (@(posedge Clk)
        (memReq.wrEn || memReq.rdEn) |->
            (memReq.addr >= Base) && (offsetAddr <= DMemBytes - 4));

endmodule

//--- regFile.sv
module regFile (
    input  logic                      Clk,
    input  logic                      arstN,
    input  logic [4:0]                rs1Addr,
    input  logic [4:0]                rs2Addr,
    output logic [corePkg::XLEN-1:0]  rs1Data,
    output logic [corePkg::XLEN-1:0]  rs2Data,
    input  logic                      wrEn,
    input  logic [4:0]                rdAddr,
    input  logic [corePkg::XLEN-1:0]  rdData
);

    logic [corePkg::XLEN-1:0] regs [32];

    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && (rdAddr != 5'd0)) begin // x0 stays zero
            regs[rdAddr] <= rdData;
        end
    end

    assign rs1Data = regs[rs1Addr];
    assign rs2Data = regs[rs2Addr];

endmodule

//--- aluExec.sv
module aluExec (
    input  logic [corePkg::XLEN-1:0]  instr,
    input  logic [corePkg::XLEN-1:0]  pc,
    input  logic [corePkg::XLEN-1:0]  rs1Data,
    input  logic [corePkg::XLEN-1:0]  rs2Data,
    input  corePkg::aluOp_t           aluOp,
    output logic [corePkg::XLEN-1:0]  aluResult,
    output logic                      branchTaken,
    output logic [corePkg::XLEN-1:0]  target
);

    logic [6:0]                opcode;
    logic [corePkg::XLEN-1:0]  immI;
    logic [corePkg::XLEN-1:0]  immS;
    logic [corePkg::XLEN-1:0]  immB;
    logic [corePkg::XLEN-1:0]  immU;
    logic [corePkg::XLEN-1:0]  immJ;
    logic [corePkg::XLEN-1:0]  imm;
    logic [corePkg::XLEN-1:0]  operandB;

    assign opcode = instr[6:0];

    // ==============================
    // Immediates
    // ==============================
    assign immI = {{20{instr[31]}}, instr[31:20]};
    assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign immU = {instr[31:12], 12'b0};
    assign immJ = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        case (opcode)
            corePkg::OpStore: imm = immS;
            corePkg::OpLui:   imm = immU;
            default:          imm = immI; // ADDI and LW
        endcase
    end

    assign operandB = (opcode == corePkg::OpReg) ? rs2Data : imm;

    // ==============================
    // Operation
    // ==============================
    always_comb begin
        case (aluOp)
            corePkg::Sub:   aluResult = rs1Data - operandB;
            corePkg::And:   aluResult = rs1Data & operandB;
            corePkg::Or:    aluResult = rs1Data | operandB;
            corePkg::Xor:   aluResult = rs1Data ^ operandB;
            corePkg::PassB: aluResult = operandB;
            default:        aluResult = rs1Data + operandB; // Also load/store address
        endcase
        if (opcode == corePkg::OpJal) begin
            aluResult = pc + 32'd4; // Link value
        end
    end

    // funct3[0] picks BNE over BEQ
    assign branchTaken = (opcode == corePkg::OpBranch) &&
                         (instr[12] ? (rs1Data != rs2Data) : (rs1Data == rs2Data));

    assign target = pc + ((opcode == corePkg::OpJal) ? immJ : immB);

endmodule

//--- pcCounter.sv
module pcCounter (
    input  logic                      Clk,
    input  logic                      arstN,
    input  logic                      pcInc,
    input  logic                      pcLoad,
    input  logic [corePkg::XLEN-1:0]  target,
    input  logic                      pcClear,
    output logic [corePkg::XLEN-1:0]  pc
);

    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            pc <= '0;
        end else if (pcClear) begin
            pc <= '0;                // New program run
        end else if (pcLoad) begin
            pc <= target;            // Taken branch or JAL
        end else if (pcInc) begin
            pc <= pc + 32'd4;
        end
    end

    // Controller steps the pc exactly once per retire transfer
    assert property (@(posedge Clk) disable iff (!arstN)
        !(pcLoad && pcInc));

endmodule

//--- coreCtrl.sv
module coreCtrl #(
    parameter int DMemOffset = 1024
) (
    input  logic                      Clk,
    input  logic                      arstN,
    input  logic                      start,
    input  logic                      loadValid,
    output logic                      loadReady,
    output logic                      loadWrEn,
    input  logic [corePkg::XLEN-1:0]  instr,
    input  logic [corePkg::XLEN-1:0]  pc,
    output logic                      pcInc,
    output logic                      pcLoad,
    output logic                      pcClear,
    output logic [corePkg::XLEN-1:0]  instrLatched,
    output corePkg::aluOp_t           aluOp,
    input  logic [corePkg::XLEN-1:0]  aluResult,
    input  logic                      branchTaken,
    input  logic [corePkg::XLEN-1:0]  rs2Data,
    output corePkg::memReq_t          memReq,
    input  logic [corePkg::XLEN-1:0]  memRdData,
    output logic                      rfWrEn,
    output logic [corePkg::XLEN-1:0]  rfWrData,
    output corePkg::retire_t          retire,
    output logic                      retireValid,
    input  logic                      retireReady,
    output logic                      halted
);

    corePkg::ctrlState_t       state;
    corePkg::ctrlState_t       nextState;
    logic [6:0]                opcode;
    logic [2:0]                funct3;
    logic                      isLoad;
    logic                      isStore;
    logic                      isJal;
    logic                      isSystem;
    logic                      writesRd;
    logic                      retireFire;
    logic [corePkg::XLEN-1:0]  storeData;
    logic [3:0]                storeByteEn;

    // ==============================
    // Decode
    // ==============================
    assign opcode   = instrLatched[6:0];
    assign funct3   = instrLatched[14:12];
    assign isLoad   = (opcode == corePkg::OpLoad);
    assign isStore  = (opcode == corePkg::OpStore);
    assign isJal    = (opcode == corePkg::OpJal);
    assign isSystem = (opcode == corePkg::OpSystem);
    assign writesRd = (opcode inside {corePkg::OpReg, corePkg::OpImm, corePkg::OpLui,
                                      corePkg::OpLoad, corePkg::OpJal}) &&
                      (instrLatched[11:7] != 5'd0);

    always_comb begin
        aluOp = corePkg::Add;
        if (opcode == corePkg::OpLui) begin
            aluOp = corePkg::PassB;
        end else if (opcode == corePkg::OpReg) begin
            case (funct3)
                3'b000:  aluOp = instrLatched[30] ? corePkg::Sub : corePkg::Add;
                3'b100:  aluOp = corePkg::Xor;
                3'b110:  aluOp = corePkg::Or;
                3'b111:  aluOp = corePkg::And;
                default: aluOp = corePkg::Add;
            endcase
        end
    end

    // ==============================
    // State machine
    // ==============================
    always_comb begin
        nextState = state;
        case (state)
            corePkg::Idle:    if (start) nextState = corePkg::Fetch;
            corePkg::Fetch:   nextState = corePkg::Execute;
            corePkg::Execute: nextState = (isLoad || isStore) ? corePkg::Memory : corePkg::Retire;
            corePkg::Memory:  nextState = corePkg::Retire;
            corePkg::Retire: begin
                if (retireFire) begin
                    nextState = isSystem ? corePkg::Halted : corePkg::Fetch;
                end
            end
            corePkg::Halted:  if (loadValid) nextState = corePkg::Idle; // Next program
            default:          nextState = corePkg::Idle;
        endcase
    end

    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            state <= corePkg::Idle;
        end else begin
            state <= nextState;
        end
    end

    always_ff @(posedge Clk) begin
        if (state == corePkg::Fetch) begin
            instrLatched <= instr;
        end
    end

    assign loadReady   = (state == corePkg::Idle);
    assign loadWrEn    = loadValid && loadReady;
    assign halted      = (state == corePkg::Halted);
    assign retireValid = (state == corePkg::Retire);
    assign retireFire  = retireValid && retireReady;

    // ==============================
    // Data memory request
    // ==============================
    always_comb begin
        if (funct3[1:0] == 2'b00) begin       // SB, byte copied to all lanes
            storeData   = {4{rs2Data[7:0]}};
            storeByteEn = 4'b0001 << aluResult[1:0];
        end else begin
            storeData   = rs2Data;
            storeByteEn = 4'b1111;
        end
    end

    always_comb begin
        memReq.addr   = aluResult;
        memReq.wrData = storeData;
        memReq.byteEn = isStore ? storeByteEn : 4'b1111;
        memReq.wrEn   = (state == corePkg::Memory) && isStore;
        memReq.rdEn   = (state == corePkg::Memory) && isLoad;
    end

    // ==============================
    // Retire record and writeback
    // ==============================
    always_ff @(posedge Clk) begin
        if (state == corePkg::Execute) begin
            retire.pc      <= pc;
            retire.instr   <= instrLatched;
            retire.rdAddr  <= writesRd ? instrLatched[11:7] : 5'd0;
            retire.rdData  <= writesRd ? aluResult : '0;
            retire.rdWrEn  <= writesRd;
            retire.memWrEn <= isStore;
            retire.memAddr <= (isLoad || isStore) ? aluResult : '0;
            retire.memData <= isStore ? storeData : '0;
            retire.byteEn  <= isStore ? storeByteEn : 4'b0000;
        end else if ((state == corePkg::Memory) && isLoad) begin
            retire.rdData  <= writesRd ? memRdData : '0; // Load data replaces address
        end
    end

    assign rfWrEn   = retireFire && retire.rdWrEn;
    assign rfWrData = retire.rdData;
    assign pcLoad   = retireFire && (isJal || branchTaken);
    assign pcInc    = retireFire && !pcLoad;
    assign pcClear  = (state == corePkg::Idle) && start;

    // Stalled record must not change under back-pressure
    assert property (@(posedge Clk) disable iff (!arstN)
        retireValid && !retireReady |=> retireValid && $stable(retire));

    // Only a halt hands the load port back, apart from reset
    assert property (@(posedge Clk) disable iff (!arstN)
        !loadReady && (state != corePkg::Halted) |=> !loadReady);

    // Address formed in Execute must land in the data window
    assert property (@(posedge Clk) disable iff (!arstN)
        (state == corePkg::Execute) && (isLoad || isStore) |-> aluResult >= DMemOffset);

endmodule

//--- refCore.sv
module refCore #(
    parameter int IMemBytes  = 1024,
    parameter int DMemBytes  = 1024,
    parameter int DMemOffset = 1024
) (
    input  logic                Clk,
    input  logic                arstN,
    input  corePkg::loadReq_t   loadReq,
    input  logic                loadValid,
    output logic                loadReady,
    input  logic                start,
    output corePkg::retire_t    retire,
    output logic                retireValid,
    input  logic                retireReady,
    output logic                halted
);

    logic                      loadWrEn;
    logic [corePkg::XLEN-1:0]  pc;
    logic [corePkg::XLEN-1:0]  instr;
    logic [corePkg::XLEN-1:0]  instrLatched;
    logic                      pcInc;
    logic                      pcLoad;
    logic                      pcClear;
    logic [corePkg::XLEN-1:0]  target;
    corePkg::aluOp_t           aluOp;
    logic [corePkg::XLEN-1:0]  aluResult;
    logic                      branchTaken;
    logic [corePkg::XLEN-1:0]  rs1Data;
    logic [corePkg::XLEN-1:0]  rs2Data;
    corePkg::memReq_t          memReq;
    logic [corePkg::XLEN-1:0]  memRdData;
    logic                      rfWrEn;
    logic [corePkg::XLEN-1:0]  rfWrData;

    // ==============================
    // Controller and program counter
    // ==============================
    coreCtrl #(.DMemOffset(DMemOffset)) ctrl0 (
        .Clk          (Clk),
        .arstN        (arstN),
        .start        (start),
        .loadValid    (loadValid),
        .loadReady    (loadReady),
        .loadWrEn     (loadWrEn),     // To instMem
        .instr        (instr),        // From instMem
        .pc           (pc),
        .pcInc        (pcInc),
        .pcLoad       (pcLoad),
        .pcClear      (pcClear),
        .instrLatched (instrLatched),
        .aluOp        (aluOp),
        .aluResult    (aluResult),
        .branchTaken  (branchTaken),
        .rs2Data      (rs2Data),
        .memReq       (memReq),       // To dataMem
        .memRdData    (memRdData),    // From dataMem
        .rfWrEn       (rfWrEn),
        .rfWrData     (rfWrData),
        .retire       (retire),
        .retireValid  (retireValid),
        .retireReady  (retireReady),
        .halted       (halted)
    );

    pcCounter pc0 (
        .Clk     (Clk),
        .arstN   (arstN),
        .pcInc   (pcInc),
        .pcLoad  (pcLoad),
        .target  (target),
        .pcClear (pcClear),
        .pc      (pc)
    );

    // ==============================
    // Datapath
    // ==============================
    regFile rf0 (
        .Clk     (Clk),
        .arstN   (arstN),
        .rs1Addr (instrLatched[19:15]),
        .rs2Addr (instrLatched[24:20]),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data),
        .wrEn    (rfWrEn),
        .rdAddr  (retire.rdAddr),
        .rdData  (rfWrData)
    );

    aluExec alu0 (
        .instr       (instrLatched),
        .pc          (pc),
        .rs1Data     (rs1Data),
        .rs2Data     (rs2Data),
        .aluOp       (aluOp),
        .aluResult   (aluResult),
        .branchTaken (branchTaken),
        .target      (target)
    );

    // ==============================
    // Memories
    // ==============================
    instMem #(.IMemBytes(IMemBytes)) imem0 (
        .Clk      (Clk),
        .loadReq  (loadReq),
        .loadWrEn (loadWrEn),
        .pc       (pc),
        .instr    (instr)
    );

    dataMem #(.DMemBytes(DMemBytes), .DMemOffset(DMemOffset)) dmem0 (
        .Clk    (Clk),
        .memReq (memReq),
        .rdData (memRdData)
    );

    // A halted core holds its pc until the next start
    assert property (@(posedge Clk) disable iff (!arstN)
        (ctrl0.state == corePkg::Halted) |=> $stable(pc));

endmodule

//--- tbRefCore.sv
module tbRefCore;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int IMemBytes      = 1024;
    localparam int DMemBytes      = 1024;
    localparam int DMemOffset     = 1024;
    localparam int ProgLen        = 40;
    localparam int NumPrograms    = 3;
    localparam int DataWords      = 8;   // Words used by loads and stores
    localparam int ClkPeriod      = 100;
    localparam int CyclesPerInstr = 6;
    localparam int WatchdogCycles = NumPrograms * (ProgLen * CyclesPerInstr + ProgLen) + 16 + 500;

    logic                Clk = 1'b0;
    logic                arstN;
    corePkg::loadReq_t   loadReq;
    logic                loadValid;
    logic                loadReady;
    logic                start;
    corePkg::retire_t    retire;
    logic                retireValid;
    logic                retireReady;
    logic                halted;

    logic [31:0]         rngState;
    logic [31:0]         progWords [ProgLen];
    logic [31:0]         modelRegs [32];
    logic [7:0]          modelMem [DMemBytes];
    logic [31:0]         modelPc;

    refCore #(
        .IMemBytes  (IMemBytes),
        .DMemBytes  (DMemBytes),
        .DMemOffset (DMemOffset)
    ) dut0 (
        .Clk         (Clk),
        .arstN       (arstN),
        .loadReq     (loadReq),
        .loadValid   (loadValid),
        .loadReady   (loadReady),
        .start       (start),
        .retire      (retire),
        .retireValid (retireValid),
        .retireReady (retireReady),
        .halted      (halted)
    );

    always #(ClkPeriod / 2) Clk = ~Clk;

    // ==============================
    // Reporting and compare tasks
    // ==============================
    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    function automatic string formatRetire(input corePkg::retire_t r);
        return $sformatf("pc=%h instr=%h rd=x%0d data=%h we=%b mwe=%b maddr=%h mdata=%h be=%b",
                         r.pc, r.instr, r.rdAddr, r.rdData, r.rdWrEn, r.memWrEn,
                         r.memAddr, r.memData, r.byteEn);
    endfunction

    task automatic checkRetire(input string testName, input corePkg::retire_t expVal,
                               input corePkg::retire_t actVal);
        if (actVal !== expVal) begin
            abortRun($sformatf("FAILED %s expected {%s} actual {%s}", testName,
                               formatRetire(expVal), formatRetire(actVal)));
        end
    endtask

    task automatic checkHalted(input string testName, input logic expVal, input logic actVal);
        if (actVal !== expVal) begin
            abortRun($sformatf("FAILED %s halted expected %b actual %b",
                               testName, expVal, actVal));
        end
    endtask

    task automatic checkLoadReady(input string testName, input logic expVal,
                                  input logic actVal);
        if (actVal !== expVal) begin
            abortRun($sformatf("FAILED %s loadReady expected %b actual %b",
                               testName, expVal, actVal));
        end
    endtask

    task automatic checkRetireValid(input string testName, input logic expVal,
                                    input logic actVal);
        if (actVal !== expVal) begin
            abortRun($sformatf("FAILED %s retireValid expected %b actual %b",
                               testName, expVal, actVal));
        end
    endtask

    // ==============================
    // Random program generation
    // ==============================
    function automatic logic [31:0] nextRand();
        logic [31:0] s;
        s = rngState;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        rngState = s;
        return s;
    endfunction

    function automatic logic [31:0] randomInstr(input int idx);
        logic [31:0] pick;
        logic [31:0] r;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] dataImm;
        logic [12:0] brImm;
        logic [20:0] jImm;
        int          span;
        pick    = nextRand();
        r       = nextRand();
        rd      = 5'(nextRand() % 8);            // Small register set for reuse
        rs1     = 5'(nextRand() % 8);
        rs2     = 5'(nextRand() % 8);
        dataImm = 12'(DMemOffset + 4 * (nextRand() % DataWords));
        span    = ProgLen - 1 - idx;             // Forward only, ECALL is the last target
        if (span > 4) begin
            span = 4;
        end
        brImm = 13'(4 * (1 + (nextRand() % span)));
        jImm  = {8'd0, brImm};
        case (pick % 13)
            0:  return {7'b0000000, rs2, rs1, 3'b000, rd, corePkg::OpReg};   // ADD
            1:  return {7'b0100000, rs2, rs1, 3'b000, rd, corePkg::OpReg};   // SUB
            2:  return {7'b0000000, rs2, rs1, 3'b111, rd, corePkg::OpReg};   // AND
            3:  return {7'b0000000, rs2, rs1, 3'b110, rd, corePkg::OpReg};   // OR
            4:  return {7'b0000000, rs2, rs1, 3'b100, rd, corePkg::OpReg};   // XOR
            5:  return {r[11:0], rs1, 3'b000, rd, corePkg::OpImm};           // ADDI
            6:  return {r[31:12], rd, corePkg::OpLui};
            7:  return {dataImm, 5'd0, 3'b010, rd, corePkg::OpLoad};         // LW
            8:  return {dataImm[11:5], rs2, 5'd0, 3'b010, dataImm[4:0], corePkg::OpStore};
            9:  return {dataImm[11:5], rs2, 5'd0, 3'b000, dataImm[4:0], corePkg::OpStore};
            10: return {brImm[12], brImm[10:5], rs2, rs1, 3'b000, brImm[4:1], brImm[11],
                        corePkg::OpBranch};                                  // BEQ
            11: return {brImm[12], brImm[10:5], rs2, rs1, 3'b001, brImm[4:1], brImm[11],
                        corePkg::OpBranch};                                  // BNE
            default: return {jImm[20], jImm[10:1], jImm[11], jImm[19:12], rd, corePkg::OpJal};
        endcase
    endfunction

    task automatic genProgram(input int progIdx);
        logic [11:0] wordImm;
        for (int i = 0; i < ProgLen; i++) begin
            wordImm = 12'(DMemOffset + 4 * i);
            if (i == ProgLen - 1) begin
                progWords[i] = 32'h0000_0073;    // ECALL
            end else if ((progIdx == 0) && (i < DataWords)) begin
                // First program clears the data words before any load
                progWords[i] = {wordImm[11:5], 5'd0, 5'd0, 3'b010, wordImm[4:0],
                                corePkg::OpStore};
            end else begin
                progWords[i] = randomInstr(i);
            end
        end
    endtask

    function automatic string mnemonic(input logic [31:0] w);
        case (w[6:0])
            corePkg::OpReg: begin
                case (w[14:12])
                    3'b000:  return w[30] ? "SUB" : "ADD";
                    3'b100:  return "XOR";
                    3'b110:  return "OR";
                    default: return "AND";
                endcase
            end
            corePkg::OpImm:    return "ADDI";
            corePkg::OpLui:    return "LUI";
            corePkg::OpLoad:   return "LW";
            corePkg::OpStore:  return (w[14:12] == 3'b000) ? "SB" : "SW";
            corePkg::OpBranch: return w[12] ? "BNE" : "BEQ";
            corePkg::OpJal:    return "JAL";
            default:           return "ECALL";
        endcase
    endfunction

    // ==============================
    // ISA reference model
    // ==============================
    function automatic logic [31:0] readModelWord(input logic [31:0] addr);
        logic [31:0] w;
        for (int lane = 0; lane < 4; lane++) begin
            w[8*lane +: 8] = modelMem[int'(addr) - DMemOffset + lane];
        end
        return w;
    endfunction

    // Cycles from Fetch to Retire, one more for a data memory access
    function automatic int retireDelay(input logic [31:0] w);
        if ((w[6:0] == corePkg::OpLoad) || (w[6:0] == corePkg::OpStore)) begin
            return 3;
        end
        return 2;
    endfunction

    task automatic modelStep(output corePkg::retire_t expRec, output logic isHalt);
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] val;
        logic [31:0] addr;
        logic [31:0] nextPc;
        logic [31:0] immI;
        logic [31:0] immS;
        logic [31:0] immB;
        logic [31:0] immJ;
        logic        wr;
        w      = progWords[modelPc / 4];
        a      = modelRegs[w[19:15]];
        b      = modelRegs[w[24:20]];
        immI   = {{20{w[31]}}, w[31:20]};
        immS   = {{20{w[31]}}, w[31:25], w[11:7]};
        immB   = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        immJ   = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        expRec = '0;
        expRec.pc    = modelPc;
        expRec.instr = w;
        wr     = 1'b0;
        val    = '0;
        isHalt = 1'b0;
        nextPc = modelPc + 32'd4;
        case (w[6:0])
            corePkg::OpReg: begin
                wr = 1'b1;
                case (w[14:12])
                    3'b000:  val = w[30] ? (a - b) : (a + b);
                    3'b100:  val = a ^ b;
                    3'b110:  val = a | b;
                    default: val = a & b;
                endcase
            end
            corePkg::OpImm: begin
                wr  = 1'b1;
                val = a + immI;
            end
            corePkg::OpLui: begin
                wr  = 1'b1;
                val = {w[31:12], 12'd0};
            end
            corePkg::OpLoad: begin
                addr = a + immI;
                wr   = 1'b1;
                val  = readModelWord(addr);
                expRec.memAddr = addr;
            end
            corePkg::OpStore: begin
                addr = a + immS;
                expRec.memWrEn = 1'b1;
                expRec.memAddr = addr;
                if (w[14:12] == 3'b000) begin                      // SB
                    expRec.memData = {4{b[7:0]}};
                    expRec.byteEn  = 4'b0001 << addr[1:0];
                    modelMem[int'(addr) - DMemOffset] = b[7:0];
                end else begin
                    expRec.memData = b;
                    expRec.byteEn  = 4'b1111;
                    for (int lane = 0; lane < 4; lane++) begin
                        modelMem[int'(addr) - DMemOffset + lane] = b[8*lane +: 8];
                    end
                end
            end
            corePkg::OpBranch: begin
                if ((a == b) != w[12]) begin                     // BNE inverts the compare
                    nextPc = modelPc + immB;
                end
            end
            corePkg::OpJal: begin
                wr     = 1'b1;
                val    = modelPc + 32'd4;
                nextPc = modelPc + immJ;
            end
            default: isHalt = 1'b1;                             // ECALL
        endcase
        if (wr && (w[11:7] != 5'd0)) begin
            expRec.rdAddr    = w[11:7];
            expRec.rdData    = val;
            expRec.rdWrEn    = 1'b1;
            modelRegs[w[11:7]] = val;
        end
        modelPc = nextPc;
    endtask

    // ==============================
    // Load, start and run
    // ==============================
    task automatic loadProgram();
        for (int i = 0; i < ProgLen; i++) begin
            loadReq.addr  = 32'(4 * i);
            loadReq.instr = progWords[i];
            loadValid     = 1'b1;
            while (!loadReady) begin
                @(negedge Clk);                  // Halted core goes to Idle first
            end
            @(negedge Clk);
        end
        loadValid = 1'b0;
    endtask

    task automatic runProgram(input int progIdx);
        corePkg::retire_t expRec;
        logic             isHalt;
        logic [31:0]      r;
        int               count;
        int               cyc;
        isHalt  = 1'b0;
        count   = 0;
        cyc     = 0;                             // Entered on the Fetch cycle
        modelPc = '0;
        while (!isHalt) begin
            r = nextRand();
            retireReady = (r % 3) != 0;          // Back-pressure about one cycle in three
            checkRetireValid($sformatf("prog%0d record %0d cycle %0d", progIdx, count, cyc),
                             cyc >= retireDelay(progWords[modelPc / 4]), retireValid);
            if (retireValid && retireReady) begin
                modelStep(expRec, isHalt);
                checkRetire($sformatf("prog%0d record %0d %s", progIdx, count,
                                      mnemonic(expRec.instr)), expRec, retire);
                checkHalted($sformatf("prog%0d record %0d", progIdx, count), 1'b0, halted);
                count++;
                cyc = -1;                        // Next falling edge sees Fetch
            end
            cyc++;
            @(negedge Clk);
        end
        retireReady = 1'b0;
        checkHalted($sformatf("prog%0d after ECALL", progIdx), 1'b1, halted);
        checkLoadReady($sformatf("prog%0d after ECALL", progIdx), 1'b0, loadReady);
    endtask

    initial begin
        rngState    = 32'hd50bccff;
        arstN       = 1'b0;
        loadReq     = '0;
        loadValid   = 1'b0;
        start       = 1'b0;
        retireReady = 1'b0;
        for (int i = 0; i < 32; i++) begin
            modelRegs[i] = '0;
        end
        for (int i = 0; i < DMemBytes; i++) begin
            modelMem[i] = '0;
        end
        repeat (16) @(negedge Clk);
        arstN = 1'b1;
        @(negedge Clk);
        checkLoadReady("after reset", 1'b1, loadReady);
        checkHalted("after reset", 1'b0, halted);

        // Registers and data memory carry over between programs
        for (int p = 0; p < NumPrograms; p++) begin
            genProgram(p);
            if (p > 0) begin
                checkLoadReady($sformatf("prog%0d before reload", p), 1'b0, loadReady);
            end
            loadProgram();
            checkLoadReady($sformatf("prog%0d loaded", p), 1'b1, loadReady);
            start = 1'b1;
            @(negedge Clk);
            start = 1'b0;
            checkLoadReady($sformatf("prog%0d running", p), 1'b0, loadReady);
            runProgram(p);
            repeat (3) @(negedge Clk);
            checkHalted($sformatf("prog%0d halt held", p), 1'b1, halted);
        end

        $display("TEST PASSED");
        $finish;
    end

    // Bound from program count and worst expected cycles per instruction
    initial begin
        #(WatchdogCycles * ClkPeriod);
        abortRun("Watchdog expired because the core stopped retiring instructions");
    end

endmodule

//--- sim.f
corePkg.sv
instMem.sv
dataMem.sv
regFile.sv
aluExec.sv
pcCounter.sv
coreCtrl.sv
refCore.sv
tbRefCore.sv
